//--- flist.f
+incdir+.
rename_pkg.sv
arch_free_list.sv
spec_free_list.sv
arch_map_table.sv
rename_free_top.sv
rename_sva.sv
rename_tb.sv

//--- rename_tb.sv
/*
  Testbench for the rename free-list top level
  Directed phases then an LFSR-driven mix, checked each cycle against a queue model
*/
`timescale 1ns/1ns
`default_nettype none
`include "rename_params.svh"

module rename_tb;

  import rename_pkg::*;

  // DUT signals
  logic                            clk;
  logic                            rst_n;
  logic [`COMMIT_WIDTH-1:0]        alloc_req;
  logic                            alloc_ok;
  preg_t [`COMMIT_WIDTH-1:0]       alloc_preg;
  logic [`COMMIT_WIDTH-1:0]        commit_valid;
  areg_t [`COMMIT_WIDTH-1:0]       commit_areg;
  preg_t [`COMMIT_WIDTH-1:0]       commit_preg;
  logic                            flush;
  fl_cnt_t                         spec_free_cnt;
  logic                            check_en;

  // Model state: both queues, committed map, in-flight instructions
  preg_t       sp_list [`PHY_REG_NUM];
  preg_t       ar_list [`PHY_REG_NUM];
  int          sp_head;
  int          sp_tail;
  int          sp_cnt;
  int          ar_head;
  int          ar_tail;
  int          ar_cnt;
  preg_t       map [`ARCH_REG_NUM];
  preg_t       q_preg [$];
  areg_t       q_areg [$];
  int          force_areg;
  logic [15:0] lfsr_q;

  rename_free_top dut (
    .clk             (clk),
    .rst_n           (rst_n),
    .alloc_req_i     (alloc_req),
    .alloc_ok_o      (alloc_ok),
    .alloc_preg_o    (alloc_preg),
    .commit_valid_i  (commit_valid),
    .commit_areg_i   (commit_areg),
    .commit_preg_i   (commit_preg),
    .flush_i         (flush),
    .spec_free_cnt_o (spec_free_cnt)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // ============================================================
  // Random bits and reporting
  // ============================================================
  // Fibonacci LFSR, x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic lfsr_bit();
    logic fb;
    fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
    lfsr_q = {lfsr_q[14:0], fb};
    return fb;
  endfunction

  function automatic int rand_bits(input int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++) begin
      v = (v << 1) | lfsr_bit();
    end
    return v;
  endfunction

  task automatic end_in_failure();
    $display("Verification failed");
    $fatal(1, "run aborted");
  endtask

  task automatic report_timeout(input string what);
    $display("Timeout: %s", what);
    end_in_failure();
  endtask

  task automatic check_preg(input string name, input preg_t got, input preg_t exp);
    if (got !== exp) begin
      $display("** Error at %0t ns: %s = %0d, expected %0d", $time, name, got, exp);
      end_in_failure();
    end
  endtask

  task automatic check_cnt(input string name, input fl_cnt_t got, input fl_cnt_t exp);
    if (got !== exp) begin
      $display("** Error at %0t ns: %s = %0d, expected %0d", $time, name, got, exp);
      end_in_failure();
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("** Error at %0t ns: %s = %b, expected %b", $time, name, got, exp);
      end_in_failure();
    end
  endtask

  // ============================================================
  // Reference model
  // ============================================================
  function automatic void model_reset();
    for (int i = 0; i < `PHY_REG_NUM; i++) begin
      sp_list[i] = preg_t'((i + `ARCH_REG_NUM) % `PHY_REG_NUM);
      ar_list[i] = sp_list[i];
    end
    for (int i = 0; i < `ARCH_REG_NUM; i++) begin
      map[i] = preg_t'(i);
    end
    sp_head    = 0;
    ar_head    = 0;
    sp_cnt     = `PHY_REG_NUM - `ARCH_REG_NUM;
    ar_cnt     = sp_cnt;
    sp_tail    = sp_cnt;
    ar_tail    = ar_cnt;
    force_areg = -1;
    lfsr_q     = 16'd11189;
  endfunction

  // Grant only when the list holds every requested register
  function automatic logic ref_ok(input logic [`COMMIT_WIDTH-1:0] req);
    int n;
    n = $countones(req);
    return (n != 0) && (sp_cnt >= n);
  endfunction

  // Lane k takes the entry past all lower requesting lanes
  function automatic preg_t ref_alloc(input logic [`COMMIT_WIDTH-1:0] req, input int k);
    int off;
    off = 0;
    for (int j = 0; j < k; j++) begin
      if (req[j]) off++;
    end
    return sp_list[(sp_head + off) % `PHY_REG_NUM];
  endfunction

  // Old mapping, unless a lower lane wrote the same register this cycle
  function automatic preg_t ref_free(input int k);
    preg_t r;
    r = map[commit_areg[k]];
    for (int j = 0; j < k; j++) begin
      if (commit_valid[j] && commit_areg[j] == commit_areg[k]) r = commit_preg[j];
    end
    return r;
  endfunction

  // Mirror one clock edge with the inputs held before it
  task automatic model_advance();
    preg_t freed [`COMMIT_WIDTH];
    int    grant;
    int    ncommit;
    grant   = (ref_ok(alloc_req) && !flush) ? $countones(alloc_req) : 0;
    ncommit = $countones(commit_valid);
    if (grant != 0) begin
      for (int k = 0; k < `COMMIT_WIDTH; k++) begin
        if (alloc_req[k]) begin
          q_preg.push_back(ref_alloc(alloc_req, k));
          q_areg.push_back(force_areg >= 0 ? areg_t'(force_areg) : areg_t'(rand_bits(5)));
        end
      end
    end
    for (int k = 0; k < `COMMIT_WIDTH; k++) begin
      freed[k] = ref_free(k);
    end
    for (int k = 0; k < `COMMIT_WIDTH; k++) begin
      if (commit_valid[k]) begin
        map[commit_areg[k]] = commit_preg[k];
        void'(q_preg.pop_front());
        void'(q_areg.pop_front());
        ar_list[ar_tail] = freed[k];
        ar_tail          = (ar_tail + 1) % `PHY_REG_NUM;
        sp_list[sp_tail] = freed[k];
        sp_tail          = (sp_tail + 1) % `PHY_REG_NUM;
      end
    end
    // Each commit frees one register, committed count holds
    ar_head = (ar_head + ncommit) % `PHY_REG_NUM;
    sp_head = (sp_head + grant) % `PHY_REG_NUM;
    sp_cnt  = sp_cnt - grant + ncommit;
    if (flush) begin
      sp_list = ar_list;
      sp_head = ar_head;
      sp_cnt  = ar_cnt;
      sp_tail = (ar_head + ar_cnt) % `PHY_REG_NUM;
      q_preg.delete();
      q_areg.delete();
    end
  endtask

  // One cycle: model the edge, then drive the next inputs
  task automatic run_cycle(input logic [`COMMIT_WIDTH-1:0] req, input int ncommit,
                           input logic do_flush);
    int                        nc;
    int                        lane;
    logic [`COMMIT_WIDTH-1:0]  cv;
    areg_t [`COMMIT_WIDTH-1:0] ca;
    preg_t [`COMMIT_WIDTH-1:0] cp;
    @(posedge clk);
    model_advance();
    nc = (ncommit < q_preg.size()) ? ncommit : q_preg.size();
    cv = '0;
    ca = '0;
    cp = '0;
    if (nc == 1) begin
      // Single commit on either lane
      lane     = rand_bits(1);
      cv[lane] = 1'b1;
      ca[lane] = q_areg[0];
      cp[lane] = q_preg[0];
    end else begin
      for (int k = 0; k < nc; k++) begin
        cv[k] = 1'b1;
        ca[k] = q_areg[k];
        cp[k] = q_preg[k];
      end
    end
    alloc_req    <= req;
    commit_valid <= cv;
    commit_areg  <= ca;
    commit_preg  <= cp;
    flush        <= do_flush;
  endtask

  task automatic drain_commits();
    int loops;
    loops = 0;
    while (q_preg.size() != 0) begin
      run_cycle('0, 2, 1'b0);
      loops++;
      if (loops > 40) report_timeout("in-flight instructions never drained");
    end
  endtask

  // Compare process, outputs settled by the falling edge
  always @(negedge clk) begin
    if (dut.u_sva.fail_cnt != 0) begin
      $display("A bound assertion fired before %0t ns", $time);
      end_in_failure();
    end
    if (check_en) begin
      check_bit("alloc_ok_o", alloc_ok, ref_ok(alloc_req));
      check_cnt("spec_free_cnt_o", spec_free_cnt, fl_cnt_t'(sp_cnt));
      for (int k = 0; k < `COMMIT_WIDTH; k++) begin
        if (alloc_req[k] && ref_ok(alloc_req)) begin
          check_preg($sformatf("alloc_preg_o[%0d]", k), alloc_preg[k], ref_alloc(alloc_req, k));
        end
        if (commit_valid[k]) begin
          check_preg($sformatf("free_preg[%0d]", k), dut.free_preg[k], ref_free(k));
        end
      end
    end
  end

  // ============================================================
  // Stimulus
  // ============================================================
  initial begin
    int                       loops;
    logic [`COMMIT_WIDTH-1:0] req_r;
    model_reset();
    rst_n        = 1'b0;
    alloc_req    = '0;
    commit_valid = '0;
    commit_areg  = '0;
    commit_preg  = '0;
    flush        = 1'b0;
    check_en     = 1'b0;
    repeat (3) @(posedge clk);
    rst_n    <= 1'b1;
    check_en = 1'b1;

    // Single and dual grants from reset contents
    run_cycle(2'b01, 0, 1'b0);
    run_cycle(2'b11, 0, 1'b0);
    run_cycle(2'b10, 0, 1'b0);

    // Exhaust the list, then hold requests against an empty list
    loops = 0;
    while (sp_cnt >= 2) begin
      run_cycle(2'b11, 0, 1'b0);
      loops++;
      if (loops > 40) report_timeout("free list never ran out");
    end
    run_cycle(2'b11, 0, 1'b0);
    run_cycle(2'b01, 0, 1'b0);
    run_cycle(2'b11, 0, 1'b0);

    // Commits free old mappings, which come back through allocation
    repeat (4) run_cycle('0, 2, 1'b0);
    run_cycle(2'b01, 1, 1'b0);
    run_cycle(2'b11, 2, 1'b0);
    run_cycle(2'b11, 0, 1'b0);
    drain_commits();

    // Two lanes retire the same destination in one cycle
    // Forced destination applies at the edge that grants the pair
    force_areg = 7;
    run_cycle(2'b11, 0, 1'b0);
    run_cycle('0, 2, 1'b0);
    force_areg = -1;
    run_cycle(2'b11, 0, 1'b0);

    // Flush with commits in the flush cycle
    drain_commits();
    repeat (3) run_cycle(2'b11, 0, 1'b0);
    run_cycle('0, 1, 1'b0);
    run_cycle(2'b11, 2, 1'b1);
    run_cycle(2'b11, 0, 1'b0);
    run_cycle(2'b01, 1, 1'b0);

    // Random mix, about one flush in sixteen cycles
    for (int c = 0; c < 600; c++) begin
      req_r = rand_bits(2);
      run_cycle(req_r, rand_bits(1) + rand_bits(1), rand_bits(4) == 15);
    end
    run_cycle('0, 0, 1'b0);
    run_cycle('0, 0, 1'b0);
    // Assertion actions of the last edge have run by the falling edge
    @(negedge clk);

    if (dut.u_sva.fail_cnt == 0) begin
      $display("Verification passed");
      $finish;
    end else begin
      $display("Assertion failures in the bound checker: %0d", dut.u_sva.fail_cnt);
      $display("Verification failed");
      $fatal(1, "run aborted");
    end
  end

endmodule

`default_nettype wire

//--- rename_sva.sv
/*
  Bound assertions for the rename free-list top level
  Count bound, grant legality and flush restore of the speculative count
*/
`timescale 1ns/1ns
`default_nettype none
`include "rename_params.svh"

module rename_sva (
  input logic                      clk,
  input logic                      rst_n,
  input logic [`COMMIT_WIDTH-1:0]  alloc_req_i,
  input logic                      alloc_ok_i,
  input logic                      flush_i,
  input rename_pkg::fl_cnt_t       spec_free_cnt_i,
  input rename_pkg::fl_cnt_t       arch_cnt_i
);

  // Failure tally
  int unsigned fail_cnt = 0;

  // Occupancy stays within the physical register count
  cnt_bound_a: assert property (@(posedge clk) disable iff (!rst_n)
    spec_free_cnt_i <= `PHY_REG_NUM)
  else begin
    fail_cnt++;
    $error("free count above capacity");
  end

  // A grant needs one free register per requesting lane
  grant_cnt_a: assert property (@(posedge clk) disable iff (!rst_n)
    alloc_ok_i |-> (spec_free_cnt_i >= $countones(alloc_req_i)))
  else begin
    fail_cnt++;
    $error("grant with too few free registers");
  end

  // Flush restores the committed count one cycle later
  flush_cnt_a: assert property (@(posedge clk) disable iff (!rst_n)
    flush_i |=> (spec_free_cnt_i == $past(arch_cnt_i)))
  else begin
    fail_cnt++;
    $error("count after flush differs from committed count");
  end

endmodule

bind rename_free_top rename_sva u_sva (
  .clk             (clk),
  .rst_n           (rst_n),
  .alloc_req_i     (alloc_req_i),
  .alloc_ok_i      (alloc_ok_o),
  .flush_i         (flush_i),
  .spec_free_cnt_i (spec_free_cnt_o),
  .arch_cnt_i      (arch_cnt_next)
);

`default_nettype wire

//--- rename_free_top.sv
/*
  Top level of the register-renaming free-list subsystem
  Rename side allocates from the speculative list, commit side frees through the map
*/
`timescale 1ns/1ns
`default_nettype none
`include "rename_params.svh"

module rename_free_top (
  input  logic                                   clk,
  input  logic                                   rst_n,
  // Rename side
  input  logic [`COMMIT_WIDTH-1:0]               alloc_req_i,
  output logic                                   alloc_ok_o,
  output rename_pkg::preg_t [`COMMIT_WIDTH-1:0]  alloc_preg_o,
  // Commit side
  input  logic [`COMMIT_WIDTH-1:0]               commit_valid_i,
  input  rename_pkg::areg_t [`COMMIT_WIDTH-1:0]  commit_areg_i,
  input  rename_pkg::preg_t [`COMMIT_WIDTH-1:0]  commit_preg_i,
  // Control and status
  input  logic                                   flush_i,
  output rename_pkg::fl_cnt_t                    spec_free_cnt_o
);

  import rename_pkg::*;

  // Frees from the committed map
  logic [`COMMIT_WIDTH-1:0]  free_valid;
  preg_t [`COMMIT_WIDTH-1:0] free_preg;

  // Architectural next state for flush restore
  preg_t [`PHY_REG_NUM-1:0]  arch_list_next;
  preg_t                     arch_head_next;
  fl_cnt_t                   arch_cnt_next;

  // ============================================================
  // Committed state
  // ============================================================
  arch_map_table u_arch_map_table (
    .clk            (clk),
    .rst_n          (rst_n),
    .commit_valid_i (commit_valid_i),
    .commit_areg_i  (commit_areg_i),
    .commit_preg_i  (commit_preg_i),
    .free_valid_o   (free_valid),
    .free_preg_o    (free_preg)
  );

  arch_free_list u_arch_free_list (
    .clk              (clk),
    .rst_n            (rst_n),
    .commit_valid_i   (commit_valid_i),
    .free_valid_i     (free_valid),
    .free_preg_i      (free_preg),
    .arch_list_next_o (arch_list_next),
    .arch_head_next_o (arch_head_next),
    .arch_cnt_next_o  (arch_cnt_next)
  );

  // Speculative list, restored from the committed side on flush
  spec_free_list u_spec_free_list (
    .clk          (clk),
    .rst_n        (rst_n),
    .flush_i      (flush_i),
    .alloc_req_i  (alloc_req_i),
    .alloc_ok_o   (alloc_ok_o),
    .alloc_preg_o (alloc_preg_o),
    .free_valid_i (free_valid),
    .free_preg_i  (free_preg),
    .arch_list_i  (arch_list_next),
    .arch_head_i  (arch_head_next),
    .arch_cnt_i   (arch_cnt_next),
    .free_cnt_o   (spec_free_cnt_o)
  );

endmodule

`default_nettype wire

//--- arch_map_table.sv
/*
  Committed architectural-to-physical register map
  Each commit lane looks up the mapping it replaces and hands it back as a free
*/
`timescale 1ns/1ns
`default_nettype none
`include "rename_params.svh"

module arch_map_table (
  input  logic                                   clk,
  input  logic                                   rst_n,
  input  logic [`COMMIT_WIDTH-1:0]               commit_valid_i,
  input  rename_pkg::areg_t [`COMMIT_WIDTH-1:0]  commit_areg_i,
  input  rename_pkg::preg_t [`COMMIT_WIDTH-1:0]  commit_preg_i,
  output logic [`COMMIT_WIDTH-1:0]               free_valid_o,
  output rename_pkg::preg_t [`COMMIT_WIDTH-1:0]  free_preg_o
);

  import rename_pkg::*;

  // One physical index per architectural register
  preg_t [`ARCH_REG_NUM-1:0] map_q;
  preg_t [`ARCH_REG_NUM-1:0] map_d;

  // ============================================================
  // Lookup and update in lane order
  // ============================================================
  always_comb begin
    map_d = map_q;
    for (int k = 0; k < `COMMIT_WIDTH; k++) begin
      // Lookup sees writes of lower lanes, same register in one cycle
      // frees the older lane's new mapping
      free_preg_o[k] = map_d[commit_areg_i[k]];
      if (commit_valid_i[k]) begin
        map_d[commit_areg_i[k]] = commit_preg_i[k];
      end
    end
  end

  // Every retiring instruction frees exactly one register
  assign free_valid_o = commit_valid_i;

  // ============================================================
  // Map storage
  // ============================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      // Identity mapping out of reset
      for (int i = 0; i < `ARCH_REG_NUM; i++) begin
        map_q[i] <= preg_t'(i);
      end
    end else begin
      map_q <= map_d;
    end
  end

endmodule

`default_nettype wire

//--- spec_free_list.sv
/*
  Speculative free list feeding rename allocation
  Grants up to COMMIT_WIDTH registers per cycle, takes back committed frees
  A flush reloads list, head and count from the architectural next state
*/
`timescale 1ns/1ns
`default_nettype none
`include "rename_params.svh"

module spec_free_list (
  input  logic                                   clk,
  input  logic                                   rst_n,
  input  logic                                   flush_i,
  input  logic [`COMMIT_WIDTH-1:0]               alloc_req_i,
  output logic                                   alloc_ok_o,
  output rename_pkg::preg_t [`COMMIT_WIDTH-1:0]  alloc_preg_o,
  input  logic [`COMMIT_WIDTH-1:0]               free_valid_i,
  input  rename_pkg::preg_t [`COMMIT_WIDTH-1:0]  free_preg_i,
  input  rename_pkg::preg_t [`PHY_REG_NUM-1:0]   arch_list_i,
  input  rename_pkg::preg_t                      arch_head_i,
  input  rename_pkg::fl_cnt_t                    arch_cnt_i,
  output rename_pkg::fl_cnt_t                    free_cnt_o
);

  import rename_pkg::*;

  // Queue storage and pointers
  preg_t [`PHY_REG_NUM-1:0] list_q;
  preg_t [`PHY_REG_NUM-1:0] list_d;
  preg_t                    head_q;
  preg_t                    head_d;
  preg_t                    tail_q;
  preg_t                    tail_d;
  fl_cnt_t                  cnt_q;
  fl_cnt_t                  cnt_d;

  // Lane bookkeeping
  fl_cnt_t                  req_cnt;
  fl_cnt_t                  grant_cnt;
  fl_cnt_t                  free_cnt;
  preg_t                    rd_idx;
  preg_t                    wr_idx;
  logic                     grant;

  // ============================================================
  // Allocation
  // ============================================================
  assign req_cnt = fl_cnt_t'($countones(alloc_req_i));

  // Level from the registered count, low with no request
  assign alloc_ok_o = (req_cnt != '0) && (cnt_q >= req_cnt);

  // Requests in a flush cycle are dropped
  assign grant     = alloc_ok_o && !flush_i;
  assign grant_cnt = grant ? req_cnt : '0;

  // Each requesting lane takes the next entry past earlier requesters
  always_comb begin
    rd_idx = head_q;
    for (int k = 0; k < `COMMIT_WIDTH; k++) begin
      alloc_preg_o[k] = list_q[rd_idx];
      if (alloc_req_i[k]) begin
        rd_idx = rd_idx + 1'b1;
      end
    end
  end

  // ============================================================
  // Frees and next state
  // ============================================================
  always_comb begin
    free_cnt = fl_cnt_t'($countones(free_valid_i));
    head_d   = preg_t'(head_q + grant_cnt);
    tail_d   = preg_t'(tail_q + free_cnt);
    cnt_d    = cnt_q - grant_cnt + free_cnt;

    // Tail slots lie outside the live range, no clash with reads
    list_d = list_q;
    wr_idx = tail_q;
    for (int i = 0; i < `COMMIT_WIDTH; i++) begin
      if (free_valid_i[i]) begin
        list_d[wr_idx] = free_preg_i[i];
        wr_idx         = wr_idx + 1'b1;
      end
    end
  end

  assign free_cnt_o = cnt_q;

  // ============================================================
  // State registers
  // ============================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < `PHY_REG_NUM; i++) begin
        list_q[i] <= preg_t'(i + `ARCH_REG_NUM);
      end
      head_q <= '0;
      tail_q <= preg_t'(`PHY_REG_NUM - `ARCH_REG_NUM);
      cnt_q  <= fl_cnt_t'(`PHY_REG_NUM - `ARCH_REG_NUM);
    end else if (flush_i) begin
      // Restore committed view, tail rebuilt from head plus count
      list_q <= arch_list_i;
      head_q <= arch_head_i;
      tail_q <= preg_t'(arch_head_i + arch_cnt_i);
      cnt_q  <= arch_cnt_i;
    end else begin
      list_q <= list_d;
      head_q <= head_d;
      tail_q <= tail_d;
      cnt_q  <= cnt_d;
    end
  end

endmodule

`default_nettype wire

//--- arch_free_list.sv
/*
  Committed free list of physical registers
  Head follows retirement in allocation order, tail collects freed registers
  Next state goes out so the speculative list can copy it on a flush
*/
`timescale 1ns/1ns
`default_nettype none
`include "rename_params.svh"

module arch_free_list (
  input  logic                                   clk,
  input  logic                                   rst_n,
  input  logic [`COMMIT_WIDTH-1:0]               commit_valid_i,
  input  logic [`COMMIT_WIDTH-1:0]               free_valid_i,
  input  rename_pkg::preg_t [`COMMIT_WIDTH-1:0]  free_preg_i,
  output rename_pkg::preg_t [`PHY_REG_NUM-1:0]   arch_list_next_o,
  output rename_pkg::preg_t                      arch_head_next_o,
  output rename_pkg::fl_cnt_t                    arch_cnt_next_o
);

  import rename_pkg::*;

  // Queue storage and pointers
  preg_t [`PHY_REG_NUM-1:0] list_q;
  preg_t [`PHY_REG_NUM-1:0] list_d;
  preg_t                    head_q;
  preg_t                    head_d;
  preg_t                    tail_q;
  preg_t                    tail_d;
  fl_cnt_t                  cnt_q;
  fl_cnt_t                  cnt_d;

  // Per-cycle lane counts and write cursor
  fl_cnt_t                  commit_cnt;
  fl_cnt_t                  free_cnt;
  preg_t                    wr_idx;

  // ============================================================
  // Next state
  // ============================================================
  always_comb begin
    commit_cnt = fl_cnt_t'($countones(commit_valid_i));
    free_cnt   = fl_cnt_t'($countones(free_valid_i));

    // Commits retire the oldest allocations, so head moves by commit count
    // Depth is a power of two, pointers wrap on overflow
    head_d = preg_t'(head_q + commit_cnt);
    tail_d = preg_t'(tail_q + free_cnt);
    cnt_d  = cnt_q - commit_cnt + free_cnt;

    // Freed registers packed at the tail in lane order
    list_d = list_q;
    wr_idx = tail_q;
    for (int i = 0; i < `COMMIT_WIDTH; i++) begin
      if (free_valid_i[i]) begin
        list_d[wr_idx] = free_preg_i[i];
        wr_idx         = wr_idx + 1'b1;
      end
    end
  end

  // Flush source for the speculative list
  assign arch_list_next_o = list_d;
  assign arch_head_next_o = head_d;
  assign arch_cnt_next_o  = cnt_d;

  // ============================================================
  // State registers
  // ============================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      // Registers above the architectural range start out free
      for (int i = 0; i < `PHY_REG_NUM; i++) begin
        list_q[i] <= preg_t'(i + `ARCH_REG_NUM);
      end
      head_q <= '0;
      tail_q <= preg_t'(`PHY_REG_NUM - `ARCH_REG_NUM);
      cnt_q  <= fl_cnt_t'(`PHY_REG_NUM - `ARCH_REG_NUM);
    end else begin
      list_q <= list_d;
      head_q <= head_d;
      tail_q <= tail_d;
      cnt_q  <= cnt_d;
    end
  end

endmodule

`default_nettype wire

//--- rename_pkg.sv
/*
  Index and count types shared by the rename free-list blocks
  Widths follow the sizing macros in the params header
*/
`default_nettype none
`include "rename_params.svh"

package rename_pkg;

  // Physical register index
  typedef logic [$clog2(`PHY_REG_NUM)-1:0] preg_t;

  // Architectural register index
  typedef logic [$clog2(`ARCH_REG_NUM)-1:0] areg_t;

  // Free-list occupancy, one extra bit so a full list fits
  typedef logic [$clog2(`PHY_REG_NUM):0] fl_cnt_t;

endpackage

`default_nettype wire

//--- rename_params.svh
/*
  Sizing macros for the rename free-list subsystem
  Included by the package, every RTL module and the testbench
*/
`ifndef RENAME_PARAMS_SVH
`define RENAME_PARAMS_SVH

// ============================================================
// Pipeline width
// ============================================================
// Lanes per cycle, shared by allocation and commit
`define COMMIT_WIDTH 2

// ============================================================
// Register file sizes
// ============================================================
// Physical registers, also the depth of each free list
`define PHY_REG_NUM 64
// Architectural registers held by the committed map
`define ARCH_REG_NUM 32

`endif
